/* design/fdbk_pkg.sv */
// Signal path types for the Cartesian feedback datapath
package fdbk_pkg;

	localparam int iq_w   = 18;  // Sample, setpoint, limit and drive width
	localparam int acc_w  = 22;  // Room for 16 summed samples
	localparam int gain_w = 16;  // Unsigned gain multiplier
	localparam int scale_w = 2;

	// Error is one bit wider than a sample, gain gets a sign bit
	localparam int prod_w = iq_w + gain_w + 2;
	localparam int sum_w  = prod_w + 1;  // Drive plus scaled correction

	typedef logic signed [iq_w-1:0]  iq_sample_t;
	typedef logic signed [acc_w-1:0] iq_acc_t;
	typedef logic [gain_w-1:0]       gain_t;
	typedef logic [scale_w-1:0]      scale_t;  // Coarse extra right shift

	// Saturation bounds of an 18 bit sample
	localparam iq_sample_t iq_max = {1'b0, {(iq_w-1){1'b1}}};
	localparam iq_sample_t iq_min = {1'b1, {(iq_w-1){1'b0}}};

endpackage

/* design/fdbk_reg_pkg.sv */
// Register map of the feedback core
package fdbk_reg_pkg;

	typedef logic [31:0] wb_data_t;   // Wishbone data
	typedef logic [2:0]  reg_addr_t;  // Word address

	// Word addresses
	localparam reg_addr_t addr_ctrl      = 3'd0;
	localparam reg_addr_t addr_set_i     = 3'd1;
	localparam reg_addr_t addr_set_q     = 3'd2;
	localparam reg_addr_t addr_gain_p    = 3'd3;
	localparam reg_addr_t addr_gain_i    = 3'd4;
	localparam reg_addr_t addr_lim_hi    = 3'd5;
	localparam reg_addr_t addr_lim_lo    = 3'd6;
	localparam reg_addr_t addr_chirp_amp = 3'd7;

	// Fields of the control word
	localparam int ctrl_chirp_bit  = 0;
	localparam int ctrl_bypass_bit = 1;
	localparam int ctrl_scale_lsb  = 2;  // Two bits of coarse scale

endpackage

/* design/fdbk_cfg_if.sv */
`timescale 1ns/1ns

// Configuration from the register block to both controllers
interface fdbk_cfg_if import fdbk_pkg::*; ();

	iq_sample_t set_i;      // Setpoints
	iq_sample_t set_q;
	gain_t      gain_p;     // Low latency path
	gain_t      gain_i;     // Integral path
	iq_sample_t lim_hi;     // Drive clamp, both channels
	iq_sample_t lim_lo;
	iq_sample_t chirp_amp;  // Fixed I amplitude in chirp mode
	logic       chirp_en;
	logic       ll_bypass;  // Drop the proportional term
	scale_t     coarse_scale;

	modport regs (
		output set_i, set_q, gain_p, gain_i, lim_hi, lim_lo,
		output chirp_amp, chirp_en, ll_bypass, coarse_scale
	);

	modport integ (
		input set_i, set_q, gain_i, lim_hi, lim_lo
	);

	modport prop (
		input set_i, set_q, gain_p, coarse_scale,
		input chirp_en, chirp_amp, ll_bypass
	);

endinterface

/* design/fdbk_regs.sv */
`timescale 1ns/1ns

// Wishbone classic slave with the eight configuration registers
module fdbk_regs import fdbk_pkg::*, fdbk_reg_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      wb_cyc,
	input  logic      wb_stb,
	input  logic      wb_we,
	input  reg_addr_t wb_adr,
	input  wb_data_t  wb_wdata,
	output wb_data_t  wb_rdata,
	output logic      wb_ack,
	fdbk_cfg_if.regs  cfg
);

	iq_sample_t set_i, set_q;
	gain_t      gain_p, gain_i;
	iq_sample_t lim_hi, lim_lo;
	iq_sample_t chirp_amp;
	logic       chirp_en, ll_bypass;
	scale_t     coarse_scale;
	logic       req;  // New request, not yet acknowledged

	// Sign extension of a sample register to bus width
	function automatic wb_data_t sext(input iq_sample_t v);
		return {{($bits(wb_data_t) - iq_w){v[iq_w-1]}}, v};
	endfunction

	// Ack low in the cycle of a request, so a held request is spaced out
	assign req = wb_cyc & wb_stb & ~wb_ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack       <= 1'b0;
			set_i        <= '0;
			set_q        <= '0;
			gain_p       <= '0;
			gain_i       <= '0;
			lim_hi       <= '0;
			lim_lo       <= '0;
			chirp_amp    <= '0;
			chirp_en     <= 1'b0;
			ll_bypass    <= 1'b0;
			coarse_scale <= '0;
		end else begin
			wb_ack <= req;  // One cycle pulse
			if (req && wb_we) begin  // Write lands on the ack edge
				case (wb_adr)
					addr_ctrl: begin
						chirp_en     <= wb_wdata[ctrl_chirp_bit];
						ll_bypass    <= wb_wdata[ctrl_bypass_bit];
						coarse_scale <= wb_wdata[ctrl_scale_lsb +: scale_w];
					end
					addr_set_i:     set_i     <= wb_wdata[iq_w-1:0];
					addr_set_q:     set_q     <= wb_wdata[iq_w-1:0];
					addr_gain_p:    gain_p    <= wb_wdata[gain_w-1:0];
					addr_gain_i:    gain_i    <= wb_wdata[gain_w-1:0];
					addr_lim_hi:    lim_hi    <= wb_wdata[iq_w-1:0];
					addr_lim_lo:    lim_lo    <= wb_wdata[iq_w-1:0];
					addr_chirp_amp: chirp_amp <= wb_wdata[iq_w-1:0];
					default: ;
				endcase
			end
		end
	end

	// Read mux, address held by the master through ack
	always_comb begin
		wb_rdata = '0;
		case (wb_adr)
			addr_ctrl: begin
				wb_rdata[ctrl_chirp_bit]               = chirp_en;
				wb_rdata[ctrl_bypass_bit]              = ll_bypass;
				wb_rdata[ctrl_scale_lsb +: scale_w]    = coarse_scale;
			end
			addr_set_i:     wb_rdata = sext(set_i);
			addr_set_q:     wb_rdata = sext(set_q);
			addr_gain_p:    wb_rdata = wb_data_t'(gain_p);  // Zero extended
			addr_gain_i:    wb_rdata = wb_data_t'(gain_i);
			addr_lim_hi:    wb_rdata = sext(lim_hi);
			addr_lim_lo:    wb_rdata = sext(lim_lo);
			addr_chirp_amp: wb_rdata = sext(chirp_amp);
			default: ;
		endcase
	end

	// Controllers see the registers directly
	assign cfg.set_i        = set_i;
	assign cfg.set_q        = set_q;
	assign cfg.gain_p       = gain_p;
	assign cfg.gain_i       = gain_i;
	assign cfg.lim_hi       = lim_hi;
	assign cfg.lim_lo       = lim_lo;
	assign cfg.chirp_amp    = chirp_amp;
	assign cfg.chirp_en     = chirp_en;
	assign cfg.ll_bypass    = ll_bypass;
	assign cfg.coarse_scale = coarse_scale;

endmodule

/* design/iq_decim.sv */
`timescale 1ns/1ns

// Per channel average over 2^decim_log2 I/Q pairs
module iq_decim import fdbk_pkg::*; #(
	parameter int decim_log2 = 2
) (
	input  logic       clk,
	input  logic       reset,
	input  iq_sample_t in_xy,
	input  logic       iq,         // High on I
	output iq_sample_t avg_i,
	output iq_sample_t avg_q,
	output logic       avg_valid   // One cycle strobe
);

	localparam int cnt_w     = (decim_log2 > 0) ? decim_log2 : 1;
	localparam int last_pair = (1 << decim_log2) - 1;

	iq_acc_t          acc_i, acc_q;
	iq_acc_t          sum_q;     // Q sum including the current sample
	logic [cnt_w-1:0] pair_cnt;
	logic             started;   // First I seen since reset
	logic             take_q;
	logic             win_end;   // Last Q of the window is here

	assign sum_q   = acc_q + iq_acc_t'(in_xy);
	assign take_q  = ~iq & started;  // Q before the first I is dropped
	assign win_end = take_q & (pair_cnt == cnt_w'(last_pair));

	always_ff @(posedge clk) begin
		if (reset) begin
			acc_i     <= '0;
			acc_q     <= '0;
			pair_cnt  <= '0;
			started   <= 1'b0;
			avg_valid <= 1'b0;
		end else begin
			avg_valid <= win_end;
			if (iq) begin
				acc_i   <= acc_i + iq_acc_t'(in_xy);
				started <= 1'b1;
			end else if (win_end) begin
				// Restart right away, next I opens the new window
				acc_i    <= '0;
				acc_q    <= '0;
				pair_cnt <= '0;
			end else if (take_q) begin
				acc_q    <= sum_q;
				pair_cnt <= pair_cnt + 1'b1;
			end
		end
	end

	// Averages held until the next window
	always_ff @(posedge clk) begin
		if (win_end) begin
			avg_i <= iq_sample_t'(acc_i >>> decim_log2);
			avg_q <= iq_sample_t'(sum_q >>> decim_log2);
		end
	end

endmodule

/* design/pi_ctrl.sv */
`timescale 1ns/1ns

// Slow integral controller, one update per decimated window
module pi_ctrl import fdbk_pkg::*; #(
	parameter int ki_shift = 12
) (
	input  logic       clk,
	input  logic       reset,
	input  iq_sample_t avg_i,
	input  iq_sample_t avg_q,
	input  logic       avg_valid,
	fdbk_cfg_if.integ  cfg,
	output iq_sample_t drive_i,
	output iq_sample_t drive_q,
	output logic [3:0] cmp_event  // I high, I low, Q high, Q low
);

	iq_sample_t next_i, next_q;
	logic       hi_i, lo_i, hi_q, lo_q;

	// One integrator step with clamp
	// Low clamp first, then the high one, so lim_hi wins on crossed limits
	function automatic iq_sample_t pi_step(
		input  iq_sample_t drive,
		input  iq_sample_t set,
		input  iq_sample_t avg,
		input  gain_t      gain,
		input  iq_sample_t lo,
		input  iq_sample_t hi,
		output logic       hi_evt,
		output logic       lo_evt
	);
		logic signed [iq_w:0]     err;
		logic signed [gain_w:0]   g;
		logic signed [prod_w-1:0] prod;
		logic signed [sum_w-1:0]  sum;
		logic signed [sum_w-1:0]  mid;
		logic                     below;

		err   = set - avg;          // 19 bits, no overflow
		g     = {1'b0, gain};       // Gain as positive signed
		prod  = g * err;
		sum   = drive + (prod >>> ki_shift);
		below = sum < lo;
		mid   = below ? lo : sum;
		hi_evt = mid > hi;
		lo_evt = below & ~hi_evt;   // Only the clamp that set the result
		return hi_evt ? hi : iq_sample_t'(mid);
	endfunction

	always_comb begin
		next_i = pi_step(drive_i, cfg.set_i, avg_i, cfg.gain_i,
			cfg.lim_lo, cfg.lim_hi, hi_i, lo_i);
		next_q = pi_step(drive_q, cfg.set_q, avg_q, cfg.gain_i,
			cfg.lim_lo, cfg.lim_hi, hi_q, lo_q);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			drive_i   <= '0;
			drive_q   <= '0;
			cmp_event <= '0;
		end else if (avg_valid) begin  // Drive holds between windows
			drive_i   <= next_i;
			drive_q   <= next_q;
			cmp_event <= {hi_i, lo_i, hi_q, lo_q};  // Cleared when no clamp
		end
	end

endmodule

/* design/ll_prop.sv */
`timescale 1ns/1ns

// Low latency proportional path on every raw sample
module ll_prop import fdbk_pkg::*; #(
	parameter int kp_shift = 12
) (
	input  logic       clk,
	input  logic       reset,
	input  iq_sample_t in_xy,
	input  logic       iq,        // High on I
	fdbk_cfg_if.prop   cfg,
	input  iq_sample_t drive_i,
	input  iq_sample_t drive_q,
	output iq_sample_t out_xy     // Channel of the previous input
);

	iq_sample_t               set, drive;
	logic signed [iq_w:0]     err;
	logic signed [gain_w:0]   g;
	logic signed [prod_w-1:0] prod;
	logic signed [sum_w-1:0]  sum;
	iq_sample_t               prop_out;
	iq_sample_t               next_out;

	// Clip to the 18 bit range
	function automatic iq_sample_t sat(input logic signed [sum_w-1:0] v);
		if (v > iq_max)
			return iq_max;
		if (v < iq_min)
			return iq_min;
		return iq_sample_t'(v);
	endfunction

	always_comb begin
		set   = iq ? cfg.set_i : cfg.set_q;  // Channel select
		drive = iq ? drive_i : drive_q;
		err   = set - in_xy;
		g     = {1'b0, cfg.gain_p};
		prod  = g * err;
		// Fine shift from the parameter, coarse one from the register
		sum      = drive + (prod >>> (kp_shift + cfg.coarse_scale));
		prop_out = sat(sum);

		if (cfg.chirp_en)
			next_out = iq ? cfg.chirp_amp : '0;  // Amplitude on I only
		else if (cfg.ll_bypass)
			next_out = drive;                    // Integral drive alone
		else
			next_out = prop_out;
	end

	always_ff @(posedge clk) begin
		if (reset)
			out_xy <= '0;
		else
			out_xy <= next_out;
	end

endmodule

/* design/fdbk_core.sv */
`timescale 1ns/1ns

// Cartesian feedback core for one cavity channel
// Slow path: decimator then integral controller
// Fast path: proportional term on each raw sample, added to the drive
module fdbk_core import fdbk_pkg::*, fdbk_reg_pkg::*; #(
	parameter int decim_log2 = 2,   // Window of 2^decim_log2 pairs
	parameter int ki_shift   = 12,
	parameter int kp_shift   = 12
) (
	input  logic       clk,
	input  logic       reset,
	input  iq_sample_t in_xy,
	input  logic       iq,          // High on the I sample
	output iq_sample_t out_xy,
	output logic [3:0] cmp_event,   // I high, I low, Q high, Q low
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  reg_addr_t  wb_adr,
	input  wb_data_t   wb_wdata,
	output wb_data_t   wb_rdata,
	output logic       wb_ack
);

	iq_sample_t avg_i, avg_q;     // Window averages
	logic       avg_valid;
	iq_sample_t drive_i, drive_q; // Integral drive, held per window

	fdbk_cfg_if cfg ();

	fdbk_regs regs (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_wdata (wb_wdata),
		.wb_rdata (wb_rdata),
		.wb_ack   (wb_ack),
		.cfg      (cfg.regs)
	);

	iq_decim #(.decim_log2(decim_log2)) decim (
		.clk       (clk),
		.reset     (reset),
		.in_xy     (in_xy),
		.iq        (iq),
		.avg_i     (avg_i),
		.avg_q     (avg_q),
		.avg_valid (avg_valid)
	);

	pi_ctrl #(.ki_shift(ki_shift)) integ (
		.clk       (clk),
		.reset     (reset),
		.avg_i     (avg_i),
		.avg_q     (avg_q),
		.avg_valid (avg_valid),
		.cfg       (cfg.integ),
		.drive_i   (drive_i),
		.drive_q   (drive_q),
		.cmp_event (cmp_event)
	);

	ll_prop #(.kp_shift(kp_shift)) prop (
		.clk     (clk),
		.reset   (reset),
		.in_xy   (in_xy),
		.iq      (iq),
		.cfg     (cfg.prop),
		.drive_i (drive_i),
		.drive_q (drive_q),
		.out_xy  (out_xy)
	);

endmodule

/* dv/fdbk_core_chk.sv */
`timescale 1ns/1ns

// Bus handshake and reset behaviour of the feedback core
module fdbk_core_chk import fdbk_pkg::*; (
	input logic       clk,
	input logic       reset,
	input logic       wb_cyc,
	input logic       wb_stb,
	input logic       wb_ack,
	input logic [3:0] cmp_event,
	input iq_sample_t out_xy
);

	// Ack is a single cycle pulse
	ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack)
		else $error("wb_ack held high for two cycles");

	// Ack only answers a request seen on the edge before
	ack_after_req: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack without a request");

	ack_event_in_reset: assert property (@(posedge clk)
		$past(reset) |-> (!wb_ack && cmp_event == 4'b0))
		else $error("wb_ack or cmp_event high out of reset");

	out_zero_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> (out_xy == '0))
		else $error("out_xy not zero after reset");

endmodule

bind fdbk_core fdbk_core_chk chk (
	.clk       (clk),
	.reset     (reset),
	.wb_cyc    (wb_cyc),
	.wb_stb    (wb_stb),
	.wb_ack    (wb_ack),
	.cmp_event (cmp_event),
	.out_xy    (out_xy)
);

/* dv/fdbk_core_tb.sv */
`timescale 1ns/1ns

module fdbk_core_tb import fdbk_pkg::*, fdbk_reg_pkg::*;;

	localparam int decim_log2 = 2;
	localparam int ki_shift   = 12;
	localparam int kp_shift   = 12;
	// Reset, then each test with two cycles per bus access, then a margin
	localparam int cycle_limit = 3 + 16 * 2 + (2 * 2 + 40) + (4 * 2 + 60)
		+ 4 * (4 * 2 + 100) + (10 * 2 + 350) + 200;

	logic       clk, reset, iq, wb_cyc, wb_stb, wb_we, wb_ack;
	iq_sample_t in_xy, out_xy;
	logic [3:0] cmp_event;
	reg_addr_t  wb_adr;
	wb_data_t   wb_wdata, wb_rdata;

	int         err_sample, err_event, err_data, err_ack, cycles;
	logic       use_rand;   // Random or constant sample stream
	iq_sample_t const_val;

	// Reference model state
	logic       m_ack, m_req, m_valid, m_started, m_chirp, m_bypass;
	logic [1:0] m_scale;
	iq_sample_t m_set_i, m_set_q, m_lim_hi, m_lim_lo, m_amp;
	gain_t      m_gain_p, m_gain_i;
	longint     m_acc_i, m_acc_q;
	int         m_cnt;
	iq_sample_t m_avg_i, m_avg_q, m_drive_i, m_drive_q, m_out, n_out, n_drv_i, n_drv_q;
	logic [3:0] m_evt, n_evt;
	wb_data_t   d;
	iq_sample_t lim;

	fdbk_core #(.decim_log2(decim_log2), .ki_shift(ki_shift), .kp_shift(kp_shift)) dut (
		.clk(clk), .reset(reset), .in_xy(in_xy), .iq(iq), .out_xy(out_xy),
		.cmp_event(cmp_event), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack)
	);

	// Proportional output with chirp, bypass and 18 bit saturation
	function automatic iq_sample_t predict_out(input iq_sample_t x, input logic is_i);
		longint set, drv, sum;
		set = is_i ? m_set_i : m_set_q;
		drv = is_i ? m_drive_i : m_drive_q;
		sum = drv + ((longint'(m_gain_p) * (set - longint'(x))) >>> (kp_shift + m_scale));
		if (m_chirp)
			return is_i ? m_amp : iq_sample_t'(0);
		if (m_bypass)
			return iq_sample_t'(drv);
		if (sum > 131071)
			sum = 131071;
		if (sum < -131072)
			sum = -131072;
		return iq_sample_t'(sum);
	endfunction

	// Integral step where the high limit wins on crossed limits
	function automatic iq_sample_t integ_step(input iq_sample_t drv, input iq_sample_t set,
			input iq_sample_t avg, output logic hi, output logic lo);
		longint sum;
		sum = longint'(drv) + ((longint'(m_gain_i) * (longint'(set) - avg)) >>> ki_shift);
		hi = sum > m_lim_hi || (sum < m_lim_lo && m_lim_lo > m_lim_hi);
		lo = sum < m_lim_lo && !hi;
		if (hi)
			return m_lim_hi;
		if (lo)
			return m_lim_lo;
		return iq_sample_t'(sum);
	endfunction

	// Readback value of a register after a write of w
	function automatic wb_data_t readback(input reg_addr_t a, input wb_data_t w);
		if (a == addr_ctrl)
			return w & 32'hf;  // Chirp, bypass and scale bits
		if (a == addr_gain_p || a == addr_gain_i)
			return w & 32'hffff;
		return {{14{w[17]}}, w[17:0]};  // Sign extended sample
	endfunction

	task automatic check_sample(input string name, input iq_sample_t exp, input iq_sample_t act);
		if (exp !== act) begin
			err_sample++;
			$display("MISMATCH %0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_event(input logic [3:0] exp, input logic [3:0] act);
		if (exp !== act) begin
			err_event++;
			$display("MISMATCH %0t cmp_event expected %b got %b", $time, exp, act);
		end
	endtask

	task automatic check_data(input wb_data_t exp, input wb_data_t act);
		if (exp !== act) begin
			err_data++;
			$display("MISMATCH %0t wb_rdata expected %h got %h", $time, exp, act);
		end
	endtask

	task automatic check_ack(input logic exp, input logic act);
		if (exp !== act) begin
			err_ack++;
			$display("MISMATCH %0t wb_ack expected %b got %b", $time, exp, act);
		end
	endtask

	task automatic wb_access(input logic we, input reg_addr_t a, input wb_data_t w,
			output wb_data_t r);
		@(posedge clk);
		#2;
		wb_cyc = 1;
		wb_stb = 1;
		wb_we = we;
		wb_adr = a;
		wb_wdata = w;
		forever begin
			@(posedge clk);
			#1;
			if (wb_ack)
				break;
		end
		r = wb_rdata;  // Valid while ack is high
		#1;
		wb_cyc = 0;
		wb_stb = 0;
		wb_we = 0;
	endtask

	task automatic wb_write(input reg_addr_t a, input wb_data_t w);
		wb_data_t r;
		wb_access(1'b1, a, w, r);
	endtask

	task automatic wb_read(input reg_addr_t a, input wb_data_t exp);
		wb_data_t r;
		wb_access(1'b0, a, '0, r);
		check_data(exp, r);
	endtask

	initial begin
		clk = 0;
		forever #10 clk = ~clk;
	end

	// Sample stream with I and Q alternating
	initial begin
		forever begin
			@(posedge clk);
			#2;
			iq = ~iq;
			in_xy = use_rand ? iq_sample_t'($urandom) : const_val;
		end
	end

	// Model stepped on each edge from the pre-edge inputs
	always @(posedge clk) begin
		if (reset) begin
			m_ack = 0;
			m_valid = 0;
			m_started = 0;
			m_acc_i = 0;
			m_acc_q = 0;
			m_cnt = 0;
			m_chirp = 0;
			m_bypass = 0;
			m_scale = 0;
			m_set_i = 0;
			m_set_q = 0;
			m_gain_p = 0;
			m_gain_i = 0;
			m_lim_hi = 0;
			m_lim_lo = 0;
			m_amp = 0;
			m_drive_i = 0;
			m_drive_q = 0;
			m_evt = 0;
			m_out = 0;
		end else begin
			n_out = predict_out(in_xy, iq);  // Uses the drive before this edge
			if (m_valid) begin
				n_drv_i = integ_step(m_drive_i, m_set_i, m_avg_i, n_evt[3], n_evt[2]);
				n_drv_q = integ_step(m_drive_q, m_set_q, m_avg_q, n_evt[1], n_evt[0]);
				m_drive_i = n_drv_i;
				m_drive_q = n_drv_q;
				m_evt = n_evt;
			end
			m_valid = 0;
			if (iq) begin
				m_acc_i += in_xy;
				m_started = 1;
			end else if (m_started) begin
				m_acc_q += in_xy;
				m_cnt++;
				if (m_cnt == (1 << decim_log2)) begin  // Window closes
					m_avg_i = iq_sample_t'(m_acc_i >>> decim_log2);
					m_avg_q = iq_sample_t'(m_acc_q >>> decim_log2);
					m_valid = 1;
					m_acc_i = 0;
					m_acc_q = 0;
					m_cnt = 0;
				end
			end
			m_out = n_out;
			m_req = wb_cyc && wb_stb && !m_ack;
			if (m_req && wb_we) begin  // Register write lands with the ack
				case (wb_adr)
					addr_ctrl: {m_scale, m_bypass, m_chirp} = wb_wdata[3:0];
					addr_set_i: m_set_i = wb_wdata[17:0];
					addr_set_q: m_set_q = wb_wdata[17:0];
					addr_gain_p: m_gain_p = wb_wdata[15:0];
					addr_gain_i: m_gain_i = wb_wdata[15:0];
					addr_lim_hi: m_lim_hi = wb_wdata[17:0];
					addr_lim_lo: m_lim_lo = wb_wdata[17:0];
					default: m_amp = wb_wdata[17:0];
				endcase
			end
			m_ack = m_req;
		end
	end

	// Compare on the falling edge once all outputs have settled
	always @(negedge clk) begin
		if (!reset) begin
			check_sample("out_xy", m_out, out_xy);
			check_event(m_evt, cmp_event);
			check_ack(m_ack, wb_ack);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hc87c));
		reset = 1;
		iq = 0;
		in_xy = '0;
		use_rand = 1;
		const_val = '0;
		wb_cyc = 0;
		wb_stb = 0;
		wb_we = 0;
		wb_adr = '0;
		wb_wdata = '0;
		err_sample = 0;
		err_event = 0;
		err_data = 0;
		err_ack = 0;
		cycles = 0;
		repeat (3) @(posedge clk);
		#2 reset = 0;

		// Register access
		for (int a = 0; a < 8; a++) begin
			d = $urandom;
			wb_write(reg_addr_t'(a), d);
			wb_read(reg_addr_t'(a), readback(reg_addr_t'(a), d));
		end

		// Chirp mode
		wb_write(addr_chirp_amp, $urandom);
		wb_write(addr_ctrl, 32'h1);
		repeat (40) @(posedge clk);

		// Bypass with drive pinned by equal limits
		lim = iq_sample_t'($urandom);
		wb_write(addr_gain_i, 0);
		wb_write(addr_lim_hi, 32'(lim));
		wb_write(addr_lim_lo, 32'(lim));
		wb_write(addr_ctrl, 32'h2);
		repeat (60) @(posedge clk);

		// Proportional path with random gains and setpoints
		for (int k = 0; k < 4; k++) begin
			wb_write(addr_set_i, $urandom);
			wb_write(addr_set_q, $urandom);
			wb_write(addr_gain_p, $urandom);
			wb_write(addr_ctrl, {28'b0, 2'(k), 2'b00});  // Coarse scale k
			repeat (100) @(posedge clk);
		end

		// Integral path where I rises to lim_hi and Q falls to lim_lo
		use_rand = 0;
		const_val = 18'sd1000;
		wb_write(addr_gain_p, 0);
		wb_write(addr_ctrl, 32'h2);
		wb_write(addr_set_i, 32'sd3000);
		wb_write(addr_set_q, -32'sd3000);
		wb_write(addr_lim_lo, -32'sd20000);
		wb_write(addr_lim_hi, 32'sd8000);
		wb_write(addr_gain_i, 4096);
		repeat (150) @(posedge clk);
		wb_write(addr_lim_hi, 32'sd100000);  // High event clears
		repeat (100) @(posedge clk);
		wb_write(addr_lim_lo, -32'sd131072);  // Low event clears
		wb_write(addr_ctrl, 32'h0);
		repeat (100) @(posedge clk);

		$display("Errors: sample %0d, event %0d, data %0d, ack %0d",
			err_sample, err_event, err_data, err_ack);
		if (err_sample + err_event + err_data + err_ack == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* fdbk_core.f */
design/fdbk_pkg.sv
design/fdbk_reg_pkg.sv
design/fdbk_cfg_if.sv
design/fdbk_regs.sv
design/iq_decim.sv
design/pi_ctrl.sv
design/ll_prop.sv
design/fdbk_core.sv
dv/fdbk_core_chk.sv
dv/fdbk_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the feedback core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fdbk_core_tb -f fdbk_core.f -o fdbk_core_sim

./obj_dir/fdbk_core_sim > sim.log 2>&1 || true
cat sim.log

grep -qx "Everything OK" sim.log
